//--- verilog/afu_config.svh
`ifndef AFU_CONFIG_SVH
`define AFU_CONFIG_SVH

// ------------------------------------------------------------
// host memory geometry
// ------------------------------------------------------------
`define AFU_CL_BITS         512
`define AFU_ADDR_BITS       58

// batch size field is one bit wider than this
`define AFU_READ_NUM_BITS   6

// ------------------------------------------------------------
// handshake line and input area, in lines from src_ptr
// ------------------------------------------------------------
`define AFU_HAND_OFFSET     50348031
`define AFU_INPUT_OFFSET    50348032
`define AFU_CL_PER_READ     4

// flag bits and fields inside the handshake line
`define AFU_TAG0_BIT        480
`define AFU_TAG1_BIT        482
`define AFU_BATCH_LSB       448
`define AFU_DONE_CODE       16

// small FIFOs, log2 of depth
`define AFU_FIFO_DEPTH_LOG  2

`endif

//--- verilog/afu_mem_pkg.sv
`include "afu_config.svh"

package afu_mem_pkg;

	// one host cache line
	typedef logic [`AFU_CL_BITS-1:0] cl_t;

	// host address in cache-line units
	typedef logic [`AFU_ADDR_BITS-1:0] cl_addr_t;

	// occurrence-table address as produced by the search engine
	typedef logic [31:0] occ_addr_t;

	// k and l lookups travel together until the read port splits them
	typedef struct packed {
		cl_addr_t addr_k;
		cl_addr_t addr_l;
	} rd_pair_t;

	// one beat toward the write port
	typedef struct packed {
		cl_addr_t addr;
		cl_t      data;
		logic     fence;
	} wr_beat_t;

	// both answers of one lookup pair
	typedef struct packed {
		cl_t line_k;
		cl_t line_l;
	} rd_resp_pair_t;

endpackage

//--- verilog/afu_ctrl_pkg.sv
`include "afu_config.svh"

package afu_ctrl_pkg;
	import afu_mem_pkg::*;

	// batch sequencing, one pass per host batch
	typedef enum logic [3:0] {
		IDLE,
		POLL_REQ,
		POLL_WAIT,
		LOAD_READ,
		RUN,
		OUTPUT,
		FENCE_1,
		STATUS,
		FENCE_2
	} batch_state_e;

	typedef logic [`AFU_READ_NUM_BITS:0]   batch_size_t;
	typedef logic [`AFU_READ_NUM_BITS+2:0] line_cnt_t;

	// ------------------------------------------------------------
	// search engine side
	// ------------------------------------------------------------
	typedef struct packed {
		logic valid;
		cl_t  data;
	} eng_load_t;

	typedef struct packed {
		logic      valid;
		occ_addr_t addr_k;
		occ_addr_t addr_l;
	} eng_req_t;

	typedef struct packed {
		logic get;
		cl_t  line_k;
		cl_t  line_l;
	} eng_resp_t;

	typedef struct packed {
		logic valid;
		cl_t  data;
	} eng_out_t;

endpackage

//--- verilog/afu_batch_ctrl.sv
`include "afu_config.svh"

module afu_batch_ctrl
	import afu_mem_pkg::*;
	import afu_ctrl_pkg::*;
(
	input  logic          CLK_200M,
	input  logic          reset_n,
	input  logic          core_start,
	input  cl_addr_t      src_ptr,
	input  cl_addr_t      dst_ptr,
	input  logic          stall,
	output logic          req_wr,
	output rd_pair_t      req_pair,
	input  logic          pair_valid,
	input  rd_resp_pair_t resp_pair,
	output logic          wr_en,
	output wr_beat_t      wr_beat,
	output logic          engine_reset_n,
	output eng_load_t     engine_load,
	output batch_size_t   batch_size,
	input  logic          read_load_done,
	input  eng_req_t      eng_req,
	output eng_resp_t     eng_resp,
	input  logic          output_request,
	output logic          output_permit,
	input  eng_out_t      eng_out,
	input  logic          output_finish
);

	batch_state_e  state;
	logic          polling_tag;
	logic          tag_hit;
	line_cnt_t     load_cnt;
	line_cnt_t     load_total;
	logic          load_gap;
	logic          load_issue;
	line_cnt_t     out_cnt;
	cl_addr_t      hand_addr;
	cl_addr_t      input_base;
	logic          load_valid;
	cl_t           load_data;
	logic          resp_get;
	rd_resp_pair_t resp_q;

	assign hand_addr  = src_ptr + cl_addr_t'(`AFU_HAND_OFFSET);
	assign input_base = src_ptr + cl_addr_t'(`AFU_INPUT_OFFSET);
	assign load_total = line_cnt_t'(batch_size) * line_cnt_t'(`AFU_CL_PER_READ);

	// host flips between the two flag bits on alternate batches
	assign tag_hit = polling_tag ? resp_pair.line_l[`AFU_TAG1_BIT]
		: resp_pair.line_l[`AFU_TAG0_BIT];

	// one load pair every other cycle, matching the read port drain rate
	assign load_issue = (state == LOAD_READ) && !stall && !load_gap && (load_cnt < load_total);

	assign engine_reset_n = (state != IDLE);
	assign engine_load    = '{valid: load_valid, data: load_data};
	assign eng_resp       = '{get: resp_get, line_k: resp_q.line_k, line_l: resp_q.line_l};

	// ------------------------------------------------------------
	// request and write beats, combinational so stall acts at once
	// ------------------------------------------------------------
	always_comb begin
		req_wr   = 1'b0;
		req_pair = '{addr_k: hand_addr, addr_l: hand_addr};
		wr_en    = 1'b0;
		wr_beat  = '{addr: '0, data: '0, fence: 1'b0};
		case (state)
			POLL_REQ: begin
				req_wr = !stall;
			end
			LOAD_READ: begin
				// same line twice keeps the response pairing intact
				req_wr          = load_issue;
				req_pair.addr_k = input_base + cl_addr_t'(load_cnt);
				req_pair.addr_l = input_base + cl_addr_t'(load_cnt);
			end
			RUN: begin
				req_wr          = eng_req.valid && !output_request && !stall;
				req_pair.addr_k = src_ptr + cl_addr_t'(eng_req.addr_k[31:4]);
				req_pair.addr_l = src_ptr + cl_addr_t'(eng_req.addr_l[31:4]);
			end
			OUTPUT: begin
				wr_en        = eng_out.valid && !stall;
				wr_beat.addr = dst_ptr + cl_addr_t'(out_cnt);
				wr_beat.data = eng_out.data;
			end
			FENCE_1, FENCE_2: begin
				wr_en         = !stall;
				wr_beat.fence = 1'b1;
			end
			STATUS: begin
				wr_en                              = !stall;
				wr_beat.addr                       = hand_addr;
				wr_beat.data[`AFU_CL_BITS-1 -: 32] = 32'(`AFU_DONE_CODE);
			end
			default: begin
			end
		endcase
	end

	// ------------------------------------------------------------
	// batch FSM
	// ------------------------------------------------------------
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			state         <= IDLE;
			polling_tag   <= 1'b0;
			load_cnt      <= '0;
			load_gap      <= 1'b0;
			out_cnt       <= '0;
			batch_size    <= '0;
			output_permit <= 1'b0;
			load_valid    <= 1'b0;
			resp_get      <= 1'b0;
		end else begin
			load_valid <= (state == LOAD_READ) && pair_valid;
			resp_get   <= (state == RUN) && pair_valid;
			case (state)
				IDLE: begin
					// polling_tag survives here, it tracks the host batch parity
					load_cnt      <= '0;
					load_gap      <= 1'b0;
					out_cnt       <= '0;
					output_permit <= 1'b0;
					if (core_start)
						state <= POLL_REQ;
				end
				POLL_REQ: begin
					if (!stall)
						state <= POLL_WAIT;
				end
				POLL_WAIT: begin
					if (pair_valid) begin
						if (tag_hit) begin
							batch_size  <= resp_pair.line_l[`AFU_BATCH_LSB +: `AFU_READ_NUM_BITS+1];
							polling_tag <= ~polling_tag;
							state       <= LOAD_READ;
						end else begin
							state <= POLL_REQ;
						end
					end
				end
				LOAD_READ: begin
					load_gap <= load_issue;
					if (load_issue)
						load_cnt <= load_cnt + 1'b1;
					if (read_load_done)
						state <= RUN;
				end
				RUN: begin
					if (output_request && !stall) begin
						output_permit <= 1'b1;
						state         <= OUTPUT;
					end
				end
				OUTPUT: begin
					if (wr_en)
						out_cnt <= out_cnt + 1'b1;
					if (output_finish && !stall) begin
						output_permit <= 1'b0;
						state         <= FENCE_1;
					end
				end
				FENCE_1: begin
					if (!stall)
						state <= STATUS;
				end
				STATUS: begin
					if (!stall)
						state <= FENCE_2;
				end
				FENCE_2: begin
					if (!stall)
						state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// response payload toward the engine
	always_ff @(posedge CLK_200M) begin
		if (pair_valid) begin
			load_data <= resp_pair.line_l;
			resp_q    <= resp_pair;
		end
	end

	// nothing enters the read or write path once the host asks to back off
	a_quiet_in_stall: assert property (@(posedge CLK_200M) disable iff (!reset_n)
		stall |-> !(req_wr || wr_en));

endmodule

//--- verilog/afu_rd_request.sv
`include "afu_config.svh"

module afu_rd_request
	import afu_mem_pkg::*;
(
	input  logic     CLK_200M,
	input  logic     reset_n,
	input  logic     tx_rd_almostfull,
	input  logic     tx_wr_almostfull,
	output logic     stall,
	input  logic     req_wr,
	input  rd_pair_t req_pair,
	output logic     tx_rd_valid,
	output cl_addr_t tx_rd_addr
);

	localparam int DEPTH = 1 << `AFU_FIFO_DEPTH_LOG;
	localparam int PTR_W = `AFU_FIFO_DEPTH_LOG + 1;

	rd_pair_t           pair_mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic               empty;
	logic               full;
	logic               phase_l;
	logic               start_pair;
	rd_pair_t           head;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[PTR_W-1] != rd_ptr[PTR_W-1])
		&& (wr_ptr[PTR_W-2:0] == rd_ptr[PTR_W-2:0]);
	assign head  = pair_mem[rd_ptr[PTR_W-2:0]];

	// a new pair only starts while the host is not backing off
	assign start_pair  = !phase_l && !empty && !stall;
	assign tx_rd_valid = start_pair || phase_l;
	assign tx_rd_addr  = phase_l ? head.addr_l : head.addr_k;

	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			stall   <= 1'b0;
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			phase_l <= 1'b0;
		end else begin
			stall <= tx_rd_almostfull | tx_wr_almostfull;
			if (req_wr && !full)
				wr_ptr <= wr_ptr + 1'b1;
			// l beat always follows its k beat, stall or not
			if (phase_l) begin
				phase_l <= 1'b0;
				rd_ptr  <= rd_ptr + 1'b1;
			end else if (start_pair) begin
				phase_l <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK_200M) begin
		if (req_wr && !full)
			pair_mem[wr_ptr[PTR_W-2:0]] <= req_pair;
	end

	a_no_write_full: assert property (@(posedge CLK_200M) disable iff (!reset_n)
		req_wr |-> !full);

endmodule

//--- verilog/afu_rd_response.sv
module afu_rd_response
	import afu_mem_pkg::*;
(
	input  logic          CLK_200M,
	input  logic          reset_n,
	input  logic          rx_rd_valid,
	input  cl_t           rx_data,
	output logic          pair_valid,
	output rd_resp_pair_t resp_pair
);

	// low for the k beat, high for the l beat
	logic steer_l;
	cl_t  k_hold;

	// ------------------------------------------------------------
	// steering, relies on requests always going out in pairs
	// ------------------------------------------------------------
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			steer_l    <= 1'b0;
			pair_valid <= 1'b0;
		end else begin
			pair_valid <= rx_rd_valid && steer_l;
			if (rx_rd_valid)
				steer_l <= ~steer_l;
		end
	end

	// k waits here until its partner arrives
	always_ff @(posedge CLK_200M) begin
		if (rx_rd_valid) begin
			if (!steer_l)
				k_hold <= rx_data;
			else
				resp_pair <= '{line_k: k_hold, line_l: rx_data};
		end
	end

endmodule

//--- verilog/afu_wr_output.sv
`include "afu_config.svh"

module afu_wr_output
	import afu_mem_pkg::*;
(
	input  logic     CLK_200M,
	input  logic     reset_n,
	input  logic     stall,
	input  logic     wr_en,
	input  wr_beat_t wr_beat,
	output logic     tx_wr_valid,
	output cl_addr_t tx_wr_addr,
	output cl_t      tx_data,
	output logic     tx_fence_valid
);

	localparam int DEPTH = 1 << `AFU_FIFO_DEPTH_LOG;
	localparam int PTR_W = `AFU_FIFO_DEPTH_LOG + 1;

	wr_beat_t         beat_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             empty;
	logic             pop;
	logic             bypass;
	logic             push;
	wr_beat_t         head;

	assign empty = (wr_ptr == rd_ptr);
	assign head  = beat_mem[rd_ptr[PTR_W-2:0]];

	// empty FIFO and open port, the beat goes straight to the output register
	assign pop    = !stall && !empty;
	assign bypass = !stall && empty && wr_en;
	assign push   = wr_en && !bypass;

	// ------------------------------------------------------------
	// registered write port
	// ------------------------------------------------------------
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			wr_ptr         <= '0;
			rd_ptr         <= '0;
			tx_wr_valid    <= 1'b0;
			tx_fence_valid <= 1'b0;
		end else begin
			tx_wr_valid    <= pop || bypass;
			tx_fence_valid <= pop ? head.fence : (bypass && wr_beat.fence);
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLK_200M) begin
		if (push)
			beat_mem[wr_ptr[PTR_W-2:0]] <= wr_beat;
		if (pop) begin
			tx_wr_addr <= head.addr;
			tx_data    <= head.data;
		end else if (bypass) begin
			tx_wr_addr <= wr_beat.addr;
			tx_data    <= wr_beat.data;
		end
	end

	a_fence_with_valid: assert property (@(posedge CLK_200M) disable iff (!reset_n)
		tx_fence_valid |-> tx_wr_valid);

endmodule

//--- verilog/afu_core.sv
module afu_core
	import afu_mem_pkg::*;
	import afu_ctrl_pkg::*;
(
	input  logic        CLK_200M,
	input  logic        reset_n,
	input  logic        core_start,
	input  cl_addr_t    src_ptr,
	input  cl_addr_t    dst_ptr,
	input  logic        tx_rd_almostfull,
	input  logic        tx_wr_almostfull,
	output logic        tx_rd_valid,
	output cl_addr_t    tx_rd_addr,
	output logic        tx_wr_valid,
	output cl_addr_t    tx_wr_addr,
	output cl_t         tx_data,
	output logic        tx_fence_valid,
	input  logic        rx_rd_valid,
	input  cl_t         rx_data,
	output logic        engine_reset_n,
	output eng_load_t   engine_load,
	output batch_size_t batch_size,
	input  logic        read_load_done,
	input  eng_req_t    eng_req,
	output eng_resp_t   eng_resp,
	input  logic        output_request,
	output logic        output_permit,
	input  eng_out_t    eng_out,
	input  logic        output_finish
);

	logic          stall;
	logic          req_wr;
	rd_pair_t      req_pair;
	logic          pair_valid;
	rd_resp_pair_t resp_pair;
	logic          wr_en;
	wr_beat_t      wr_beat;

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------
	afu_batch_ctrl u_batch_ctrl (
		.CLK_200M       (CLK_200M),
		.reset_n        (reset_n),
		.core_start     (core_start),
		.src_ptr        (src_ptr),
		.dst_ptr        (dst_ptr),
		.stall          (stall),
		.req_wr         (req_wr),
		.req_pair       (req_pair),
		.pair_valid     (pair_valid),
		.resp_pair      (resp_pair),
		.wr_en          (wr_en),
		.wr_beat        (wr_beat),
		.engine_reset_n (engine_reset_n),
		.engine_load    (engine_load),
		.batch_size     (batch_size),
		.read_load_done (read_load_done),
		.eng_req        (eng_req),
		.eng_resp       (eng_resp),
		.output_request (output_request),
		.output_permit  (output_permit),
		.eng_out        (eng_out),
		.output_finish  (output_finish)
	);

	// ------------------------------------------------------------
	// host memory paths
	// ------------------------------------------------------------
	afu_rd_request u_rd_request (
		.CLK_200M         (CLK_200M),
		.reset_n          (reset_n),
		.tx_rd_almostfull (tx_rd_almostfull),
		.tx_wr_almostfull (tx_wr_almostfull),
		.stall            (stall),
		.req_wr           (req_wr),
		.req_pair         (req_pair),
		.tx_rd_valid      (tx_rd_valid),
		.tx_rd_addr       (tx_rd_addr)
	);

	afu_rd_response u_rd_response (
		.CLK_200M    (CLK_200M),
		.reset_n     (reset_n),
		.rx_rd_valid (rx_rd_valid),
		.rx_data     (rx_data),
		.pair_valid  (pair_valid),
		.resp_pair   (resp_pair)
	);

	afu_wr_output u_wr_output (
		.CLK_200M       (CLK_200M),
		.reset_n        (reset_n),
		.stall          (stall),
		.wr_en          (wr_en),
		.wr_beat        (wr_beat),
		.tx_wr_valid    (tx_wr_valid),
		.tx_wr_addr     (tx_wr_addr),
		.tx_data        (tx_data),
		.tx_fence_valid (tx_fence_valid)
	);

endmodule

//--- test/afu_core_tb.sv
module afu_core_tb
	import afu_mem_pkg::*;
	import afu_ctrl_pkg::*;
;

	localparam int TMO = 2000;
	localparam cl_addr_t SRC = 58'h1_0000_0000;
	localparam cl_addr_t DST = 58'h2_0000_0040;
	localparam cl_t OUT_BASE = 512'h1000;

	logic CLK_200M, reset_n, core_start;
	cl_addr_t src_ptr, dst_ptr, tx_rd_addr, tx_wr_addr;
	logic tx_rd_almostfull, tx_wr_almostfull, tx_rd_valid, tx_wr_valid, tx_fence_valid;
	logic rx_rd_valid, engine_reset_n, read_load_done, output_request, output_permit;
	logic output_finish;
	cl_t rx_data, tx_data;
	eng_load_t engine_load;
	batch_size_t batch_size;
	eng_req_t eng_req;
	eng_resp_t eng_resp;
	eng_out_t eng_out;

	int errors = 0;
	int cyc = 0;
	int last_due = 0;
	int load_idx = 0;
	logic tag0 = 0;
	logic tag1 = 0;
	logic rd_phase = 0;
	logic stall_m = 0;
	wire af = tx_rd_almostfull | tx_wr_almostfull;
	cl_addr_t hand_addr, input_base;
	cl_addr_t pend_addr[$], rd_log[$], wr_addr_log[$];
	int pend_due[$];
	cl_t wr_data_log[$];
	logic wr_fence_log[$];

	assign hand_addr  = SRC + 58'd50348031;
	assign input_base = SRC + 58'd50348032;

	afu_core DUT (.*);

	initial begin
		CLK_200M = 0;
		forever #4 CLK_200M = ~CLK_200M;
	end

	// host memory contents as the core should see them
	function automatic cl_t mem_line(cl_addr_t a);
		cl_t l;
		if (a == hand_addr) begin
			l = '0;
			l[480] = tag0;
			l[482] = tag1;
			l[448 +: 7] = 7'd2;
		end else begin
			l = {8{6'b0, a}};
		end
		return l;
	endfunction

	task automatic check_equal(string name, logic [511:0] exp, logic [511:0] act);
		assert (exp === act) else begin
			errors++;
			$display("Fail %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic fail_timeout(string what);
		$display("timeout while waiting for %s", what);
		$display("errors: %0d", errors + 1);
		$display("tests failed");
		$finish;
	endtask

	task automatic step();
		@(posedge CLK_200M);
		#1;
	endtask

	// ------------------------------------------------------------
	// monitors and memory model
	// ------------------------------------------------------------
	always @(negedge CLK_200M) begin
		int due;
		if (reset_n && tx_rd_valid) begin
			due = cyc + 2 + int'($urandom_range(3, 0));
			if (due <= last_due)
				due = last_due + 1;
			last_due = due;
			pend_addr.push_back(tx_rd_addr);
			pend_due.push_back(due);
			rd_log.push_back(tx_rd_addr);
			rd_phase <= ~rd_phase;
		end
		if (reset_n && tx_wr_valid) begin
			wr_addr_log.push_back(tx_wr_addr);
			wr_data_log.push_back(tx_data);
			wr_fence_log.push_back(tx_fence_valid);
		end
		if (reset_n && engine_load.valid) begin
			check_equal("load", mem_line(input_base + cl_addr_t'(load_idx)), engine_load.data);
			load_idx++;
		end
	end

	// in-order answers, 2 to 5 cycles after each request
	always @(posedge CLK_200M) begin
		cyc = cyc + 1;
		stall_m <= af;
		#1;
		rx_rd_valid = 1'b0;
		if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
			rx_rd_valid = 1'b1;
			rx_data = mem_line(pend_addr.pop_front());
			void'(pend_due.pop_front());
		end
	end

	a_wr_quiet: assert property (@(negedge CLK_200M) disable iff (!reset_n)
		$past(af, 2) |-> !tx_wr_valid)
		else begin
			errors++;
			$display("write beat sent while almostfull was held");
		end

	a_rd_quiet: assert property (@(negedge CLK_200M) disable iff (!reset_n)
		($past(af, 1) && !rd_phase) |-> !tx_rd_valid)
		else begin
			errors++;
			$display("new read pair started while almostfull was held");
		end

	// ------------------------------------------------------------
	// engine model
	// ------------------------------------------------------------
	task automatic load_phase();
		int t = 0;
		int n_load = 0;
		while (load_idx < 8 && t < TMO) begin
			step();
			t++;
		end
		if (load_idx < 8)
			fail_timeout("engine load lines");
		check_equal("batch_size", 2, batch_size);
		foreach (rd_log[j])
			if (rd_log[j] != hand_addr)
				n_load++;
		check_equal("load_reads", 16, n_load);
		for (int j = 0; j < rd_log.size(); j++) begin
			if (j < rd_log.size() - 16)
				check_equal("poll_addr", hand_addr, rd_log[j]);
			else
				check_equal("load_addr", input_base + cl_addr_t'((j - rd_log.size() + 16) / 2),
					rd_log[j]);
		end
		rd_log.delete();
		read_load_done = 1'b1;
		step();
		read_load_done = 1'b0;
	endtask

	task automatic lookups();
		occ_addr_t ak, al;
		int t;
		for (int n = 0; n < 3; n++) begin
			ak = $urandom & 32'h00ff_ffff;
			al = $urandom & 32'h00ff_ffff;
			eng_req = '{valid: 1'b1, addr_k: ak, addr_l: al};
			step();
			eng_req.valid = 1'b0;
			t = 0;
			while (!eng_resp.get && t < TMO) begin
				step();
				t++;
			end
			if (!eng_resp.get)
				fail_timeout("lookup response");
			check_equal("resp_k", mem_line(SRC + cl_addr_t'(ak >> 4)), eng_resp.line_k);
			check_equal("resp_l", mem_line(SRC + cl_addr_t'(al >> 4)), eng_resp.line_l);
			check_equal("lookup_reads", 2, rd_log.size());
			check_equal("read_k", SRC + cl_addr_t'(ak >> 4), rd_log[0]);
			check_equal("read_l", SRC + cl_addr_t'(al >> 4), rd_log[1]);
			rd_log.delete();
		end
	endtask

	// results with optional write back-pressure, then the closing beats
	task automatic output_close(logic bp);
		int t = 0;
		int idx = 0;
		int bp_cnt = 0;
		output_request = 1'b1;
		while (!output_permit && t < TMO) begin
			step();
			t++;
		end
		if (!output_permit)
			fail_timeout("output permit");
		eng_out = '{valid: 1'b1, data: OUT_BASE};
		t = 0;
		while (idx < 4 && t < TMO) begin
			@(posedge CLK_200M);
			if (eng_out.valid && !stall_m)
				idx++;
			#1;
			tx_wr_almostfull = bp && idx >= 1 && bp_cnt < 6;
			if (tx_wr_almostfull)
				bp_cnt++;
			eng_out = '{valid: idx < 4, data: OUT_BASE + cl_t'(idx)};
			t++;
		end
		output_finish = 1'b1;
		t = 0;
		while ((output_permit || wr_addr_log.size() < 7) && t < TMO) begin
			step();
			t++;
		end
		if (wr_addr_log.size() < 7)
			fail_timeout("batch close beats");
		output_finish = 1'b0;
		output_request = 1'b0;
		repeat (5) step();
		check_equal("write_count", 7, wr_addr_log.size());
		for (int j = 0; j < 4; j++) begin
			check_equal("out_addr", DST + cl_addr_t'(j), wr_addr_log[j]);
			check_equal("out_data", OUT_BASE + cl_t'(j), wr_data_log[j]);
			check_equal("out_fence", 0, wr_fence_log[j]);
		end
		check_equal("fence1_addr", 0, wr_addr_log[4]);
		check_equal("fence1", 1, wr_fence_log[4]);
		check_equal("status_addr", hand_addr, wr_addr_log[5]);
		check_equal("status_code", 16, wr_data_log[5][511:480]);
		check_equal("status_fence", 0, wr_fence_log[5]);
		check_equal("fence2", 1, wr_fence_log[6]);
		wr_addr_log.delete();
		wr_data_log.delete();
		wr_fence_log.delete();
		rd_log.delete();
	endtask

	task automatic poll_only(int reads);
		int t = 0;
		while (rd_log.size() < reads && t < TMO) begin
			step();
			t++;
		end
		if (rd_log.size() < reads)
			fail_timeout("poll reads");
		foreach (rd_log[j])
			check_equal("poll_addr", hand_addr, rd_log[j]);
		check_equal("no_load", 0, load_idx);
	endtask

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		void'($urandom(32'he404_2d66));
		reset_n = 0;
		core_start = 0;
		src_ptr = SRC;
		dst_ptr = DST;
		tx_rd_almostfull = 0;
		tx_wr_almostfull = 0;
		rx_rd_valid = 0;
		rx_data = '0;
		read_load_done = 0;
		eng_req = '0;
		output_request = 0;
		eng_out = '0;
		output_finish = 0;
		repeat (8) step();
		reset_n = 1;
		check_equal("reset_outputs", 0, {tx_rd_valid, tx_wr_valid, tx_fence_valid,
			engine_load.valid, eng_resp.get, output_permit, engine_reset_n});

		// first batch, handshake flag 480
		core_start = 1;
		step();
		core_start = 0;
		check_equal("engine_reset_n", 1, engine_reset_n);
		poll_only(6);
		tag0 = 1;
		load_phase();
		lookups();
		output_close(1'b1);

		// second batch waits for flag 482, with read back-pressure while polling
		load_idx = 0;
		core_start = 1;
		step();
		core_start = 0;
		// almostfull rises as the first poll pair enters the FIFO
		tx_rd_almostfull = 1;
		repeat (8) step();
		tx_rd_almostfull = 0;
		poll_only(8);
		tag1 = 1;
		load_phase();
		lookups();
		output_close(1'b0);

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- afu_core.f
+incdir+verilog
verilog/afu_mem_pkg.sv
verilog/afu_ctrl_pkg.sv
verilog/afu_batch_ctrl.sv
verilog/afu_rd_request.sv
verilog/afu_rd_response.sv
verilog/afu_wr_output.sv
verilog/afu_core.sv
test/afu_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = afu_core_tb
FLIST     = afu_core.f
PASS_MSG  = all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
